//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = rv_core_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation passed

.PHONY: sim lint clean

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/rv_alu.sv
// Single-cycle combinational ALU; the branch compare always looks at both operands
`timescale 1ns/1ps

module rv_alu import rv_isa_pkg::*, rv_core_pkg::*; (
    input  word_t    op_a,
    input  word_t    op_b,
    input  decoded_t dec,
    output word_t    result,
    output logic     branch_taken
);

    logic [4:0] shamt;

    assign shamt = op_b[4:0];  // Upper bits ignored per ISA

    always_comb begin
        case (dec.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << shamt;
            alu_slt:    result = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu:   result = word_t'(op_a < op_b);   // SLTIU too, on sign-extended imm
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> shamt;
            alu_sra:    result = word_t'($signed(op_a) >>> shamt);
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            f3_beq:  branch_taken = (op_a == op_b);
            f3_bne:  branch_taken = (op_a != op_b);
            f3_blt:  branch_taken = ($signed(op_a) < $signed(op_b));
            f3_bge:  branch_taken = ($signed(op_a) >= $signed(op_b));
            f3_bltu: branch_taken = (op_a < op_b);
            f3_bgeu: branch_taken = (op_a >= op_b);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

//--- rtl/rv_control.sv
// Fixed 5-cycle sequencer; memories must answer one cycle after each strobe, no stall input
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_control import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    rv_regfile_if.core  rf,
    input  decoded_t    dec,
    input  word_t       alu_result,
    input  logic        branch_taken,
    output word_t       op_a,
    output word_t       op_b,
    output word_t       instr_reg,
    input  word_t       instr_out,
    input  word_t       data_out,
    output logic        instr_read,
    output word_t       instr_addr,
    output logic        data_read,
    output logic [3:0]  data_write,
    output word_t       data_addr,
    output word_t       data_in
);

    seq_state_t state;
    word_t      pc;
    word_t      pc_plus4;
    word_t      next_pc;
    word_t      alu_q;      // Data address, jump target or write-back value
    word_t      store_q;
    logic       taken_q;
    logic       writes_rd;

    assign pc_plus4 = pc + `RV_INSTR_STEP;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_fetch;
            pc    <= `RV_RESET_PC;
        end else begin
            case (state)
                st_fetch:   state <= st_latch;
                st_latch:   state <= st_execute;
                st_execute: state <= st_memory;
                st_memory:  state <= st_writeback;
                default: begin
                    state <= st_fetch;
                    pc    <= next_pc;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_latch) begin
            instr_reg <= instr_out;
        end
        if (state == st_execute) begin
            alu_q   <= alu_result;
            taken_q <= branch_taken;
            store_q <= rf.rs2_data;
        end
    end

    assign op_a = dec.use_pc  ? pc      : rf.rs1_data;
    assign op_b = dec.use_imm ? dec.imm : rf.rs2_data;

    always_comb begin
        case (dec.iclass)
            cls_branch: next_pc = taken_q ? pc + dec.imm : pc_plus4;
            cls_jal:    next_pc = alu_q;
            cls_jalr:   next_pc = {alu_q[`RV_XLEN-1:1], 1'b0};  // Bit 0 cleared
            default:    next_pc = pc_plus4;                     // Illegal just steps on
        endcase
    end

    always_comb begin
        case (dec.iclass)
            cls_load:          rf.rd_data = data_out;
            cls_jal, cls_jalr: rf.rd_data = pc_plus4;  // Link address
            default:           rf.rd_data = alu_q;
        endcase
    end

    assign writes_rd = (dec.iclass == cls_alu)  || (dec.iclass == cls_load) ||
                       (dec.iclass == cls_jal)  || (dec.iclass == cls_jalr) ||
                       (dec.iclass == cls_upper);

    assign rf.rs1_idx = dec.rs1;
    assign rf.rs2_idx = dec.rs2;
    assign rf.rd_idx  = dec.rd;
    assign rf.rd_we   = (state == st_writeback) && writes_rd;

    // Memory strobes
    assign instr_read = (state == st_fetch);
    assign instr_addr = pc;
    assign data_read  = (state == st_memory) && (dec.iclass == cls_load);
    assign data_write = ((state == st_memory) && (dec.iclass == cls_store)) ? 4'b1111 : 4'b0000;
    assign data_addr  = alu_q;
    assign data_in    = store_q;

endmodule

//--- rtl/rv_core.sv
// RV32I core top; word accesses only, synchronous memories with one-cycle read latency
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  word_t       instr_out,
    input  word_t       data_out,
    output logic        instr_read,
    output word_t       instr_addr,
    output logic        data_read,
    output logic [3:0]  data_write,
    output word_t       data_addr,
    output word_t       data_in
);

    word_t    instr_reg;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_result;
    logic     branch_taken;
    decoded_t dec;

    rv_regfile_if rf_bus ();

    rv_control control_i (
        .clk          (clk),
        .rst          (rst),
        .rf           (rf_bus.core),
        .dec          (dec),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .op_a         (op_a),
        .op_b         (op_b),
        .instr_reg    (instr_reg),
        .instr_out    (instr_out),
        .data_out     (data_out),
        .instr_read   (instr_read),
        .instr_addr   (instr_addr),
        .data_read    (data_read),
        .data_write   (data_write),
        .data_addr    (data_addr),
        .data_in      (data_in)
    );

    rv_decode decode_i (
        .instr (instr_reg),
        .dec   (dec)
    );

    rv_alu alu_i (
        .op_a         (op_a),
        .op_b         (op_b),
        .dec          (dec),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    rv_regfile regfile_i (
        .clk (clk),
        .rst (rst),
        .rf  (rf_bus.rf)
    );

endmodule

//--- rtl/rv_core_pkg.sv
// Microarchitecture types of the five-state core; depends on rv_isa_pkg being compiled first
package rv_core_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        st_fetch,
        st_latch,
        st_execute,
        st_memory,
        st_writeback
    } seq_state_t;

    // Ten RV32I operations plus a pass-through for LUI
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or,  alu_and,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0] {
        cls_alu,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_upper,    // LUI and AUIPC
        cls_illegal
    } instr_class_t;

    typedef struct packed {
        instr_class_t iclass;
        alu_op_t      alu_op;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        reg_idx_t     rd;
        word_t        imm;      // Already sign-extended
        logic [2:0]   funct3;
        logic         use_imm;  // Operand B from imm
        logic         use_pc;   // Operand A from PC
    } decoded_t;

endpackage

//--- rtl/rv_decode.sv
// Combinational decoder; anything outside the supported subset decodes as cls_illegal
`timescale 1ns/1ps

module rv_decode import rv_isa_pkg::*, rv_core_pkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    instr_fields_t f;
    word_t         imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_t       funct_op;
    logic          alt;

    assign f   = instr;
    assign alt = (f.funct7 == f7_alt);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // Operation for OP and OP-IMM; SUB exists only in register form
    always_comb begin
        case (f.funct3)
            f3_add_sub: funct_op = (alt && f.opcode == op_reg) ? alu_sub : alu_add;
            f3_sll:     funct_op = alu_sll;
            f3_slt:     funct_op = alu_slt;
            f3_sltu:    funct_op = alu_sltu;
            f3_xor:     funct_op = alu_xor;
            f3_srl_sra: funct_op = alt ? alu_sra : alu_srl;
            f3_or:      funct_op = alu_or;
            f3_and:     funct_op = alu_and;
            default:    funct_op = alu_add;
        endcase
    end

    always_comb begin
        dec         = '0;
        dec.iclass  = cls_illegal;
        dec.alu_op  = alu_add;
        dec.rs1     = f.rs1;
        dec.rs2     = f.rs2;
        dec.rd      = f.rd;
        dec.funct3  = f.funct3;
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        case (f.opcode)
            op_reg: begin
                dec.use_imm = 1'b0;
                dec.alu_op  = funct_op;
                if (f.funct7 == f7_base || (alt && (f.funct3 == f3_add_sub ||
                                                    f.funct3 == f3_srl_sra))) begin
                    dec.iclass = cls_alu;
                end
            end
            op_imm: begin
                dec.alu_op = funct_op;
                // Shift immediates carry funct7 in imm[11:5]
                if ((f.funct3 != f3_sll && f.funct3 != f3_srl_sra) || f.funct7 == f7_base ||
                    (alt && f.funct3 == f3_srl_sra)) begin
                    dec.iclass = cls_alu;
                end
            end
            op_load:   if (f.funct3 == f3_word) dec.iclass = cls_load;
            op_store: begin
                dec.imm = imm_s;
                if (f.funct3 == f3_word) dec.iclass = cls_store;
            end
            op_branch: begin
                dec.imm     = imm_b;
                dec.use_imm = 1'b0;            // ALU compares rs1 with rs2
                if (f.funct3[2:1] != 2'b01) dec.iclass = cls_branch;
            end
            op_jal: begin
                dec.iclass = cls_jal;
                dec.imm    = imm_j;
                dec.use_pc = 1'b1;
            end
            op_jalr:   if (f.funct3 == f3_jalr) dec.iclass = cls_jalr;
            op_lui: begin
                dec.iclass = cls_upper;
                dec.imm    = imm_u;
                dec.alu_op = alu_pass_b;
            end
            op_auipc: begin
                dec.iclass = cls_upper;
                dec.imm    = imm_u;
                dec.use_pc = 1'b1;
            end
            default: dec.iclass = cls_illegal;
        endcase
    end

endmodule

//--- rtl/rv_isa_pkg.sv
// RV32I encodings for the subset kept here; byte/half memory and the M group are absent
package rv_isa_pkg;

`include "rv_macros.svh"

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_idx_t;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_t;

    // ALU selects, shared by R-type and I-type
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // Branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [2:0] f3_word = 3'b010;  // LW / SW width
    localparam logic [2:0] f3_jalr = 3'b000;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;  // SUB, SRA, SRAI

    // R-type layout; other formats reuse these slices
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_fields_t;

endpackage

//--- rtl/rv_macros.svh
// Core-wide constants; XLEN other than 32 is not supported by the decoder or the ALU
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_REG_COUNT 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// No compressed instructions, so every step is one word
`define RV_INSTR_STEP 32'd4

`endif

//--- rtl/rv_regfile.sv
// Flop-based register file; reads are combinational, x0 reads zero and ignores writes
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_regfile import rv_isa_pkg::*; (
    input  logic clk,
    input  logic rst,
    rv_regfile_if.rf rf
);

    word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.rd_we && rf.rd_idx != '0) begin
            regs[rf.rd_idx] <= rf.rd_data;
        end
    end

    // x0 hardwired
    assign rf.rs1_data = (rf.rs1_idx == '0) ? '0 : regs[rf.rs1_idx];
    assign rf.rs2_data = (rf.rs2_idx == '0) ? '0 : regs[rf.rs2_idx];

endmodule

//--- rtl/rv_regfile_if.sv
// Two asynchronous read ports and one write port; the write takes effect on the clock edge
`timescale 1ns/1ps

interface rv_regfile_if import rv_isa_pkg::*; ();

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;

    reg_idx_t rd_idx;
    word_t    rd_data;
    logic     rd_we;

    modport core (output rs1_idx, rs2_idx, rd_idx, rd_data, rd_we,
                  input  rs1_data, rs2_data);

    modport rf   (input  rs1_idx, rs2_idx, rd_idx, rd_data, rd_we,
                  output rs1_data, rs2_data);

endinterface

//--- tests/tb_program.svh
// RV32I encoders and ISA reference results for the testbench; word loads and stores only
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
endfunction

// SW only
function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opcode);
    return {imm, rd, opcode};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// ALU result by funct3; alt selects SUB or SRA
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a, b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

`endif

//--- tests/rv_core_tb.sv
// Testbench for rv_core; program fits in 256 words, stores land at 0x100 and up
`timescale 1ns/1ps

module rv_core_tb;

    `include "tb_program.svh"

    localparam int          run_limit = 2000;   // Cycles after reset release
    localparam logic [31:0] nop_word  = 32'h0000_0013;

    logic        clk;
    logic        rst;
    logic [31:0] instr_out = '0;
    logic [31:0] data_out = '0;
    logic        instr_read;
    logic [31:0] instr_addr;
    logic        data_read;
    logic [3:0]  data_write;
    logic [31:0] data_addr;
    logic [31:0] data_in;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] shadow [32];   // Architectural register values as the program builds
    logic [31:0] lfsr;
    logic [31:0] pc;
    logic [31:0] store_ptr;

    // Expected trace with each entry tagged by its test
    logic [31:0] fetch_addr_q [$];
    int          fetch_test_q [$];
    logic [31:0] load_addr_q [$];
    int          load_test_q [$];
    logic [31:0] store_addr_q [$];
    logic [31:0] store_data_q [$];
    int          store_test_q [$];

    string test_names [6] = '{"reset", "sequencing", "arithmetic", "load", "control flow",
                              "x0 writes"};
    int    checks [6] = '{default: 0};
    int    errors [6] = '{default: 0};
    int    cycle = 0;
    int    last_fetch = -1;
    logic  done = 1'b0;

    rv_core rv_core_i (
        .clk        (clk),
        .rst        (rst),
        .instr_out  (instr_out),
        .data_out   (data_out),
        .instr_read (instr_read),
        .instr_addr (instr_addr),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_in    (data_in)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Synchronous memories with one cycle of read latency
    always @(posedge clk) begin
        if (instr_read) instr_out <= imem[instr_addr[9:2]];
        if (data_read) data_out <= dmem[data_addr[9:2]];
        if (data_write == 4'b1111) dmem[data_addr[9:2]] <= data_in;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input int test, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        checks[test]++;
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, name, got, exp);
            errors[test]++;
        end
    endtask

    task automatic emit(input logic [31:0] word, input int test);
        imem[pc[9:2]] = word;
        fetch_addr_q.push_back(pc);
        fetch_test_q.push_back(test);
        pc = pc + 4;
    endtask

    task automatic put_reg(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0) shadow[rd] = value;
    endtask

    task automatic expect_store(input logic [4:0] rs, input int test);
        emit(enc_s(store_ptr[11:0], rs, 5'd0), test);
        store_addr_q.push_back(store_ptr);
        store_data_q.push_back(shadow[rs]);
        store_test_q.push_back(test);
        store_ptr = store_ptr + 4;
    endtask

    // LUI takes the rounded upper part so ADDI's sign extension lands on value
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value, input int test);
        logic [31:0] hi;
        hi = value + 32'h800;
        emit(enc_u(hi[31:12], rd, 7'b0110111), test);
        emit(enc_i(value[11:0], rd, 3'b000, rd, 7'b0010011), test);
        put_reg(rd, value);
    endtask

    task automatic op_rr(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input int test);
        emit(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, rd), test);
        put_reg(rd, alu_ref(f3, alt, shadow[1], shadow[2]));
        expect_store(rd, test);
    endtask

    task automatic op_ri(input logic [2:0] f3, input logic [31:0] imm, input logic [4:0] rd,
                         input int test);
        emit(enc_i(imm[11:0], 5'd1, f3, rd, 7'b0010011), test);
        put_reg(rd, alu_ref(f3, f3 == 3'd5 && imm[10], shadow[1], {{20{imm[11]}}, imm[11:0]}));
        expect_store(rd, test);
    endtask

    // Forward branch over one NOP
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, rs2);
        emit(enc_b(13'd8, rs2, rs1, f3), 4);
        emit(nop_word, 4);
        if (branch_ref(f3, shadow[rs1], shadow[rs2])) begin
            // Taken branch never fetches the NOP
            void'(fetch_addr_q.pop_back());
            void'(fetch_test_q.pop_back());
        end
    endtask

    task automatic check_fetch();
        int t;
        assert (fetch_addr_q.size() > 0) else begin
            $display("Fetch from %h after the expected trace ran out", instr_addr);
            errors[1]++;
        end
        if (fetch_addr_q.size() > 0) begin
            t = fetch_test_q.pop_front();
            check_value(t, "instr_addr", instr_addr, fetch_addr_q.pop_front());
            if (last_fetch < 0) check_value(0, "first fetch cycle", 32'(cycle), 32'd1);
            else check_value(1, "fetch spacing", 32'(cycle - last_fetch), 32'd5);
            last_fetch = cycle;
            if (fetch_addr_q.size() == 0 && store_addr_q.size() == 0 &&
                load_addr_q.size() == 0) done = 1'b1;
        end
    endtask

    task automatic check_load();
        int t;
        assert (load_addr_q.size() > 0) else begin
            $display("Load from %h that the program never issues", data_addr);
            errors[3]++;
        end
        if (load_addr_q.size() > 0) begin
            t = load_test_q.pop_front();
            check_value(t, "data_addr", data_addr, load_addr_q.pop_front());
        end
    endtask

    task automatic check_store();
        int t;
        assert (store_addr_q.size() > 0) else begin
            $display("Store of %h to %h that the program never issues", data_in, data_addr);
            errors[2]++;
        end
        if (store_addr_q.size() > 0) begin
            t = store_test_q.pop_front();
            check_value(t, "data_write", 32'(data_write), 32'hf);
            check_value(t, "data_addr", data_addr, store_addr_q.pop_front());
            check_value(t, "data_in", data_in, store_data_q.pop_front());
        end
    endtask

    // Outputs settle between edges
    always @(negedge clk) begin
        if (rst) begin
            check_value(0, "data_read", 32'(data_read), 32'd0);
            check_value(0, "data_write", 32'(data_write), 32'd0);
        end else if (!done) begin
            cycle++;
            if (last_fetch < 0) begin
                check_value(0, "data_read", 32'(data_read), 32'd0);
                check_value(0, "data_write", 32'(data_write), 32'd0);
            end
            if (instr_read) check_fetch();
            if (data_read) check_load();
            if (data_write != 4'b0000) check_store();
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] imm;
        logic [31:0] at;
        int          waited;
        int          total_checks;
        int          total_errors;

        rst = 1'b1;
        lfsr = 32'h4362_a1cc;
        pc = 32'h0;
        store_ptr = 32'h100;
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[7:0], 24'h00_0000};   // Opcode 0, decodes as illegal
            dmem[i] = 32'hd47a_0000 | 32'(i);
        end
        for (int i = 0; i < 32; i++) shadow[i] = '0;

        // Opposite sign bits so signed and unsigned compares disagree
        a = take_bits(32) | 32'h8000_0000;
        b = take_bits(32) & 32'h7fff_ffff;
        load_const(5'd1, a, 1);
        load_const(5'd2, b, 1);
        for (int f = 0; f < 8; f++) begin
            op_rr(3'(f), 1'b0, 5'd3, 2);
            if (f == 0 || f == 5) op_rr(3'(f), 1'b1, 5'd3, 2);   // SUB, SRA
        end
        for (int f = 0; f < 8; f++) begin
            imm = take_bits(12);
            if (f == 1 || f == 5) imm = imm & 32'h1f;
            op_ri(3'(f), imm, 5'd4, 2);
        end
        op_ri(3'd5, 32'h400 | take_bits(5), 5'd4, 2);           // SRAI
        r = take_bits(20);
        emit(enc_u(r[19:0], 5'd5, 7'b0110111), 2);
        put_reg(5'd5, {r[19:0], 12'b0});
        expect_store(5'd5, 2);
        at = pc;
        r = take_bits(20);
        emit(enc_u(r[19:0], 5'd6, 7'b0010111), 2);
        put_reg(5'd6, at + {r[19:0], 12'b0});
        expect_store(5'd6, 2);

        // LW from word 16 then add 1 and store
        r = take_bits(32);
        dmem[16] = r;
        emit(enc_i(12'h040, 5'd0, 3'b010, 5'd7, 7'b0000011), 3);
        load_addr_q.push_back(32'h40);
        load_test_q.push_back(3);
        emit(enc_i(12'd1, 5'd7, 3'b000, 5'd7, 7'b0010011), 3);
        put_reg(5'd7, r + 1);
        expect_store(5'd7, 3);

        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                branch_case(3'(f), 5'd1, 5'd2);
                branch_case(3'(f), 5'd2, 5'd1);
                branch_case(3'(f), 5'd1, 5'd1);
            end
        end
        emit(enc_j(21'd12, 5'd8), 4);      // Skips two words
        put_reg(5'd8, pc);
        pc = pc + 8;
        expect_store(5'd8, 4);
        load_const(5'd9, pc + 16, 4);
        emit(enc_i(12'd1, 5'd9, 3'b000, 5'd10, 7'b1100111), 4);   // Odd target so bit 0 must clear
        put_reg(5'd10, pc);
        pc = pc + 4;
        expect_store(5'd10, 4);

        op_ri(3'd0, 32'd5, 5'd0, 5);       // ADDI x0 then SW x0
        emit(enc_j(21'd0, 5'd0), 4);
        fetch_addr_q.push_back(pc - 4);    // Self-jump fetched again
        fetch_test_q.push_back(4);

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        waited = 0;
        while (!done && waited < run_limit) begin
            @(posedge clk);
            waited++;
        end

        if (!done) begin
            $display("Timeout: %0d fetches, %0d loads and %0d stores never arrived",
                     fetch_addr_q.size(), load_addr_q.size(), store_addr_q.size());
        end
        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < 6; t++) begin
            $display("Test %s: %0d checks, %0d errors", test_names[t], checks[t], errors[t]);
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("Total: %0d checks, %0d errors", total_checks, total_errors);
        if (done && total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+rtl
+incdir+tests
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/rv_regfile_if.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_control.sv
rtl/rv_core.sv
tests/rv_core_tb.sv
